/* verilog/audio_fft_pkg.sv */
//********************
// shared types for the audio FFT path
// fixed-point twiddle constant functions
//********************
package audio_fft_pkg;

   typedef logic signed [23:0] audio_t;  // one audio sample
   typedef logic signed [31:0] fix_t;    // internal real or imag part
   typedef logic signed [15:0] tw_t;     // twiddle component, Q1.14
   typedef logic [63:0]        power_t;  // squared magnitude

   typedef struct packed {
      fix_t re;
      fix_t im;
   } cplx_t;

   typedef struct packed {
      logic  sop;
      logic  eop;
      cplx_t data;
   } fft_beat_t;

   typedef struct packed {
      logic   sop;
      logic   eop;
      power_t power;
   } power_beat_t;

   localparam int  TW_FRAC = 14;  // twiddle fraction bits
   localparam real PI      = 3.14159265358979323846;

   // round half away from zero
   function automatic int round_real(input real v);
      return (v < 0.0) ? -$rtoi(-v + 0.5) : $rtoi(v + 0.5);
   endfunction

   function automatic tw_t twiddle_cos(input int k, input int log2n);
      real ang;
      ang = 2.0 * PI * k / real'(1 << log2n);
      return tw_t'(round_real($cos(ang) * real'(1 << TW_FRAC)));
   endfunction

   // negative sine, so W = cos + j*twiddle_sin
   function automatic tw_t twiddle_sin(input int k, input int log2n);
      real ang;
      ang = 2.0 * PI * k / real'(1 << log2n);
      return tw_t'(round_real(-$sin(ang) * real'(1 << TW_FRAC)));
   endfunction

endpackage

/* verilog/audio_cdc_fifo.sv */
//********************
// dual-clock FIFO, audio clock into clk_50m
// gray pointers, reset sync, sticky overflow
//********************
`timescale 1ns/1ps

module audio_cdc_fifo #(
   parameter int FIFO_AW = 5
) (
   input  logic                  clk_50m,
   input  logic                  i_rst,
   input  logic                  i_audio_clk,
   input  logic                  i_wr,
   input  audio_fft_pkg::audio_t i_wr_data,
   input  logic                  i_rd,
   output audio_fft_pkg::audio_t o_rd_data,
   output logic                  o_empty,
   output logic                  o_overflow
);
   import audio_fft_pkg::*;

   localparam int DEPTH = 1 << FIFO_AW;

   typedef logic [FIFO_AW:0] ptr_t;  // one extra bit for wrap

   function automatic ptr_t to_gray(input ptr_t b);
      return b ^ (b >> 1);
   endfunction

   audio_t     mem [DEPTH];
   logic [1:0] wr_rst_sync;
   logic       wr_rst;
   ptr_t       wr_bin, wr_bin_next, wr_gray;
   ptr_t       rd_gray_s1, rd_gray_s2;
   logic       full;
   logic       wr_ovf;
   ptr_t       rd_bin, rd_bin_next, rd_gray;
   ptr_t       wr_gray_s1, wr_gray_s2;
   logic [1:0] ovf_sync;

   // reset into the audio domain
   always_ff @(posedge i_audio_clk) begin
      wr_rst_sync <= {wr_rst_sync[0], i_rst};
   end
   assign wr_rst = wr_rst_sync[1];

   assign wr_bin_next = wr_bin + 1'b1;
   // full when top two gray bits differ and the rest match
   assign full = (wr_gray == {~rd_gray_s2[FIFO_AW:FIFO_AW-1], rd_gray_s2[FIFO_AW-2:0]});

   always_ff @(posedge i_audio_clk) begin
      if (wr_rst) begin
         wr_bin     <= '0;
         wr_gray    <= '0;
         rd_gray_s1 <= '0;
         rd_gray_s2 <= '0;
         wr_ovf     <= 1'b0;
      end else begin
         rd_gray_s1 <= rd_gray;
         rd_gray_s2 <= rd_gray_s1;
         if (i_wr && !full) begin
            wr_bin  <= wr_bin_next;
            wr_gray <= to_gray(wr_bin_next);
         end
         if (i_wr && full) wr_ovf <= 1'b1;  // sample lost, flag sticks
      end
   end

   always_ff @(posedge i_audio_clk) begin
      if (i_wr && !full) mem[wr_bin[FIFO_AW-1:0]] <= i_wr_data;
   end

   assign rd_bin_next = rd_bin + 1'b1;
   assign o_empty     = (rd_gray == wr_gray_s2);
   assign o_overflow  = ovf_sync[1];

   always_ff @(posedge clk_50m) begin
      if (i_rst) begin
         rd_bin     <= '0;
         rd_gray    <= '0;
         wr_gray_s1 <= '0;
         wr_gray_s2 <= '0;
         ovf_sync   <= '0;
      end else begin
         wr_gray_s1 <= wr_gray;
         wr_gray_s2 <= wr_gray_s1;
         ovf_sync   <= {ovf_sync[0], wr_ovf};
         if (i_rd && !o_empty) begin
            rd_bin  <= rd_bin_next;
            rd_gray <= to_gray(rd_bin_next);
         end
      end
   end

   always_ff @(posedge clk_50m) begin
      if (i_rd && !o_empty) o_rd_data <= mem[rd_bin[FIFO_AW-1:0]];  // data valid next cycle
   end

   // the frame controller must only strobe a non-empty FIFO
   a_no_rd_empty: assert property (@(posedge clk_50m) disable iff (i_rst) !(i_rd && o_empty));

endmodule

/* verilog/fft_frame_ctrl.sv */
//********************
// FIFO reader that frames samples for the FFT core
//********************
`timescale 1ns/1ps

module fft_frame_ctrl #(
   parameter int FFT_LOG2N = 4
) (
   input  logic                  clk_50m,
   input  logic                  i_rst,
   input  logic                  i_empty,
   input  audio_fft_pkg::audio_t i_rd_data,
   input  logic                  i_ready,
   output logic                  o_rd,
   output logic                  o_valid,
   output audio_fft_pkg::cplx_t  o_sample,
   output logic                  o_sop,
   output logic                  o_eop
);
   import audio_fft_pkg::*;

   logic [FFT_LOG2N-1:0] rd_cnt;      // reads issued in this frame
   logic                 frame_done;  // N reads out, wait for ready to drop

   assign o_rd = !i_empty && i_ready && !frame_done;

   always_ff @(posedge clk_50m) begin
      if (i_rst) begin
         rd_cnt     <= '0;
         frame_done <= 1'b0;
         o_valid    <= 1'b0;
         o_sop      <= 1'b0;
         o_eop      <= 1'b0;
      end else begin
         o_valid <= o_rd;
         o_sop   <= o_rd && (rd_cnt == '0);
         o_eop   <= o_rd && (rd_cnt == '1);
         if (o_rd) rd_cnt <= rd_cnt + 1'b1;
         // ready stays high a little after the last sample, so hold off
         if (o_rd && (rd_cnt == '1)) begin
            frame_done <= 1'b1;
         end else if (!i_ready) begin
            frame_done <= 1'b0;
         end
      end
   end

   // FIFO output is already registered, just widen it
   assign o_sample.re = fix_t'(i_rd_data);
   assign o_sample.im = '0;

   // core drops ready only between frames
   a_ready_frame: assert property (@(posedge clk_50m) disable iff (i_rst)
      $fell(i_ready) |-> (rd_cnt == '0));

endmodule

/* verilog/fft_radix2_core.sv */
//********************
// iterative in-place radix-2 DIT FFT
// load, butterfly and unload phases
//********************
`timescale 1ns/1ps

module fft_radix2_core #(
   parameter int FFT_LOG2N = 4
) (
   input  logic                     clk_50m,
   input  logic                     i_rst,
   input  logic                     i_valid,
   input  audio_fft_pkg::cplx_t     i_sample,
   input  logic                     i_sop,
   input  logic                     i_eop,
   output logic                     o_ready,
   output logic                     o_valid,
   output audio_fft_pkg::fft_beat_t o_beat
);
   import audio_fft_pkg::*;

   localparam int AW     = FFT_LOG2N;
   localparam int N      = 1 << AW;
   localparam int SW     = $clog2(AW);
   localparam int PROD_W = 49;  // 32x16 products plus one bit for the sum
   localparam logic signed [PROD_W-1:0] RND = PROD_W'(1) <<< (TW_FRAC - 1);

   typedef enum logic [1:0] {LOAD, COMPUTE, UNLOAD} state_t;

   function automatic logic [AW-1:0] bit_rev(input logic [AW-1:0] a);
      logic [AW-1:0] r;
      for (int i = 0; i < AW; i++) begin
         r[i] = a[AW-1-i];
      end
      return r;
   endfunction

   state_t              state;
   cplx_t               mem [N];
   tw_t                 tw_re [N/2];
   tw_t                 tw_im [N/2];
   logic [AW-1:0]       ld_idx, ld_cur;
   logic [AW-1:0]       ul_idx;
   logic [SW-1:0]       stg;       // stage minus one
   logic [AW-2:0]       bf;        // butterfly within the stage
   logic                wr_phase;  // 0 read, 1 write
   logic [AW-1:0]       half, low_mask, top_addr, bot_addr;
   logic [AW-2:0]       tw_idx;
   cplx_t               bf_a, bf_b;
   tw_t                 w_re, w_im;
   logic signed [PROD_W-1:0] p_re_full, p_im_full;
   fix_t                p_re, p_im;
   cplx_t               bf_top, bf_bot;

   for (genvar k = 0; k < N/2; k++) begin : g_tw
      assign tw_re[k] = twiddle_cos(k, AW);
      assign tw_im[k] = twiddle_sin(k, AW);
   end

   assign ld_cur = i_sop ? '0 : ld_idx;  // sop realigns the frame

   // butterfly pair: insert a zero bit at position stg into bf
   always_comb begin
      half      = '0;
      half[stg] = 1'b1;
      low_mask  = half - 1'b1;
      top_addr  = (({1'b0, bf} & ~low_mask) << 1) | ({1'b0, bf} & low_mask);
      bot_addr  = top_addr | half;
      tw_idx    = (bf & low_mask[AW-2:0]) << (AW - 1 - stg);
   end

   // complex product, each component rounded then shifted
   assign p_re_full = $signed(bf_b.re) * w_re - $signed(bf_b.im) * w_im + RND;
   assign p_im_full = $signed(bf_b.re) * w_im + $signed(bf_b.im) * w_re + RND;
   assign p_re      = p_re_full[TW_FRAC +: 32];
   assign p_im      = p_im_full[TW_FRAC +: 32];

   assign bf_top.re = bf_a.re + p_re;
   assign bf_top.im = bf_a.im + p_im;
   assign bf_bot.re = bf_a.re - p_re;
   assign bf_bot.im = bf_a.im - p_im;

   always_ff @(posedge clk_50m) begin
      if (i_rst) begin
         state    <= LOAD;
         ld_idx   <= '0;
         ul_idx   <= '0;
         stg      <= '0;
         bf       <= '0;
         wr_phase <= 1'b0;
         o_ready  <= 1'b0;
         o_valid  <= 1'b0;
      end else begin
         o_ready <= (state == LOAD);    // one cycle behind the state
         o_valid <= (state == UNLOAD);
         case (state)
            LOAD: begin
               if (i_valid) begin
                  ld_idx <= ld_cur + 1'b1;
                  if (ld_cur == '1) state <= COMPUTE;
               end
            end
            COMPUTE: begin
               wr_phase <= ~wr_phase;
               if (wr_phase) begin
                  bf <= bf + 1'b1;
                  if (bf == '1) begin
                     if (stg == SW'(AW - 1)) begin
                        stg   <= '0;
                        state <= UNLOAD;
                     end else begin
                        stg <= stg + 1'b1;
                     end
                  end
               end
            end
            UNLOAD: begin
               ul_idx <= ul_idx + 1'b1;
               if (ul_idx == '1) state <= LOAD;
            end
            default: state <= LOAD;
         endcase
      end
   end

   always_ff @(posedge clk_50m) begin
      if (state == LOAD && i_valid) mem[bit_rev(ld_cur)] <= i_sample;
      if (state == COMPUTE && wr_phase) begin
         mem[top_addr] <= bf_top;
         mem[bot_addr] <= bf_bot;
      end
   end

   // operand fetch and output beat
   always_ff @(posedge clk_50m) begin
      if (!wr_phase) begin
         bf_a <= mem[top_addr];
         bf_b <= mem[bot_addr];
         w_re <= tw_re[tw_idx];
         w_im <= tw_im[tw_idx];
      end
      o_beat.sop  <= (state == UNLOAD) && (ul_idx == '0);
      o_beat.eop  <= (state == UNLOAD) && (ul_idx == '1);
      o_beat.data <= mem[ul_idx];
   end

   a_valid_ready: assert property (@(posedge clk_50m) disable iff (i_rst)
      i_valid |-> o_ready);

   // controller framing must agree with the load index
   a_eop_aligned: assert property (@(posedge clk_50m) disable iff (i_rst)
      (i_valid && state == LOAD) |-> (i_eop == (ld_cur == '1)));

endmodule

/* verilog/spectrum_power.sv */
//********************
// per-bin power, re^2 + im^2
// two-stage pipeline with frame markers
//********************
`timescale 1ns/1ps

module spectrum_power (
   input  logic                       clk_50m,
   input  logic                       i_rst,
   input  logic                       i_valid,
   input  audio_fft_pkg::fft_beat_t   i_beat,
   output logic                       o_valid,
   output audio_fft_pkg::power_beat_t o_beat
);
   import audio_fft_pkg::*;

   power_t sq_re, sq_im;  // stage 1 squares
   logic   sop_d, eop_d;
   logic   valid_d;

   always_ff @(posedge clk_50m) begin
      if (i_rst) begin
         valid_d <= 1'b0;
         o_valid <= 1'b0;
      end else begin
         valid_d <= i_valid;
         o_valid <= valid_d;
      end
   end

   always_ff @(posedge clk_50m) begin
      // squares are non-negative, 64 bits is enough
      sq_re <= $signed(i_beat.data.re) * $signed(i_beat.data.re);
      sq_im <= $signed(i_beat.data.im) * $signed(i_beat.data.im);
      sop_d <= i_beat.sop;
      eop_d <= i_beat.eop;

      o_beat.sop   <= sop_d;
      o_beat.eop   <= eop_d;
      o_beat.power <= sq_re + sq_im;  // stage 2
   end

endmodule

/* verilog/audio_fft_top.sv */
//********************
// audio spectrum front end top level
//********************
`timescale 1ns/1ps

module audio_fft_top #(
   parameter int FFT_LOG2N = 4,
   parameter int FIFO_AW   = 5
) (
   input  logic                       clk_50m,
   input  logic                       i_rst,
   input  logic                       i_audio_clk,
   input  logic                       i_audio_valid,
   input  audio_fft_pkg::audio_t      i_audio_data,
   output logic                       o_valid,
   output audio_fft_pkg::power_beat_t o_beat,
   output logic                       o_overflow
);
   import audio_fft_pkg::*;

   audio_t    fifo_data;
   logic      fifo_empty, fifo_rd;
   logic      core_ready;
   logic      smp_valid, smp_sop, smp_eop;
   cplx_t     smp;
   logic      fft_valid;
   fft_beat_t fft_beat;

   audio_cdc_fifo #(.FIFO_AW(FIFO_AW)) u_fifo (
      .clk_50m(clk_50m), .i_rst(i_rst), .i_audio_clk(i_audio_clk),
      .i_wr(i_audio_valid), .i_wr_data(i_audio_data), .i_rd(fifo_rd),
      .o_rd_data(fifo_data), .o_empty(fifo_empty), .o_overflow(o_overflow)
   );

   fft_frame_ctrl #(.FFT_LOG2N(FFT_LOG2N)) u_ctrl (
      .clk_50m(clk_50m), .i_rst(i_rst), .i_empty(fifo_empty), .i_rd_data(fifo_data),
      .i_ready(core_ready), .o_rd(fifo_rd), .o_valid(smp_valid), .o_sample(smp),
      .o_sop(smp_sop), .o_eop(smp_eop)
   );

   fft_radix2_core #(.FFT_LOG2N(FFT_LOG2N)) u_core (
      .clk_50m(clk_50m), .i_rst(i_rst), .i_valid(smp_valid), .i_sample(smp),
      .i_sop(smp_sop), .i_eop(smp_eop), .o_ready(core_ready),
      .o_valid(fft_valid), .o_beat(fft_beat)
   );

   spectrum_power u_power (
      .clk_50m(clk_50m), .i_rst(i_rst), .i_valid(fft_valid), .i_beat(fft_beat),
      .o_valid(o_valid), .o_beat(o_beat)
   );

endmodule

/* tb/fft_ref_model.svh */
//********************
// integer reference FFT, bit-reversed load
// rounded twiddles and per-bin power
//********************
`ifndef FFT_REF_MODEL_SVH
`define FFT_REF_MODEL_SVH

localparam real MODEL_PI = 3.14159265358979323846;

function automatic int bit_reverse(input int a, input int bits);
   int r;
   r = 0;
   for (int i = 0; i < bits; i++) begin
      if (a[i]) r = r | (1 << (bits - 1 - i));
   end
   return r;
endfunction

// scale by 2^14 and round to nearest
function automatic longint twiddle_q14(input real v);
   return longint'($rtoi($floor(v * 16384.0 + 0.5)));
endfunction

function automatic longint wrap_32(input longint v);
   return longint'(int'(v));  // 32-bit register width
endfunction

function automatic void fft_power_model(input int log2n, input longint x[64],
                                        output longint unsigned pw[64]);
   int     n, half, k, top, bot;
   longint re[64], im[64];
   longint w_re, w_im, p_re, p_im;
   n = 1 << log2n;
   for (int i = 0; i < n; i++) begin
      re[bit_reverse(i, log2n)] = x[i];
      im[bit_reverse(i, log2n)] = 0;
   end
   for (int s = 1; s <= log2n; s++) begin
      half = 1 << (s - 1);
      for (int g = 0; g < n; g += 2 * half) begin
         for (int j = 0; j < half; j++) begin
            k    = j * (n / (2 * half));
            w_re = twiddle_q14($cos(2.0 * MODEL_PI * k / n));
            w_im = twiddle_q14(-$sin(2.0 * MODEL_PI * k / n));
            top  = g + j;
            bot  = top + half;
            // rounded shift of the complex product
            p_re = wrap_32((re[bot] * w_re - im[bot] * w_im + 8192) >>> 14);
            p_im = wrap_32((re[bot] * w_im + im[bot] * w_re + 8192) >>> 14);
            re[bot] = wrap_32(re[top] - p_re);
            im[bot] = wrap_32(im[top] - p_im);
            re[top] = wrap_32(re[top] + p_re);
            im[top] = wrap_32(im[top] + p_im);
         end
      end
   end
   for (int i = 0; i < n; i++) pw[i] = re[i] * re[i] + im[i] * im[i];
endfunction

`endif

/* tb/audio_fft_tb.sv */
//********************
// testbench for the audio FFT front end
// directed and random frames, burst overflow, reset
//********************
`timescale 1ns/1ps

module audio_fft_tb;
   import audio_fft_pkg::*;

   localparam int LOG2N      = 4;
   localparam int N          = 1 << LOG2N;
   localparam int RAND_FR    = 20;
   localparam int BURST_LEN  = 200;
   localparam int FRAMES     = 2 + RAND_FR + BURST_LEN / N + 1 + 4;
   localparam int MAX_CYCLES = 4 * (FRAMES * (N + N * LOG2N + N) + 200);

   `include "fft_ref_model.svh"

   logic        clk_50m, i_audio_clk, i_rst, i_audio_valid;
   audio_t      i_audio_data;
   logic        o_valid, o_overflow;
   power_beat_t o_beat;
   int          seed = 32'h4413af01;
   int          errors, checks, cycles, frames_seen, beat_cnt;
   bit          check_values, ovf_low, ovf_high;
   string       test_name;
   audio_t      acc_q[$];    // samples taken by the FIFO
   power_t      exp_q[$];
   audio_t      frame_buf[N];

   audio_fft_top #(.FFT_LOG2N(LOG2N), .FIFO_AW(5)) dut (
      .clk_50m(clk_50m), .i_rst(i_rst), .i_audio_clk(i_audio_clk),
      .i_audio_valid(i_audio_valid), .i_audio_data(i_audio_data),
      .o_valid(o_valid), .o_beat(o_beat), .o_overflow(o_overflow)
   );

   always #10 clk_50m = ~clk_50m;
   always #7 i_audio_clk = ~i_audio_clk;

   task automatic compare_value(input string name, input longint unsigned expected,
                                input longint unsigned actual);
      checks++;
      assert (actual == expected) else begin
         errors++;
         $display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
      end
   endtask

   task automatic require(input bit cond, input string what);
      checks++;
      assert (cond) else begin
         errors++;
         $display("error: %s", what);
      end
   endtask

   task automatic apply_reset();
      @(posedge clk_50m);
      i_rst <= 1'b1;
      repeat (5) @(posedge clk_50m);
      i_rst <= 1'b0;
      repeat (10) @(posedge clk_50m);  // audio side leaves reset later
   endtask

   // sparse mode puts random idle cycles before the sample
   task automatic push_sample(input audio_t s, input bit sparse);
      int r;
      r = sparse ? $random(seed) : 0;
      while (r[1:0] != 2'b00) begin
         @(posedge i_audio_clk);
         i_audio_valid <= 1'b0;
         r = $random(seed);
      end
      @(posedge i_audio_clk);
      i_audio_valid <= 1'b1;
      i_audio_data  <= s;
   endtask

   task automatic send_frame(input bit sparse);
      for (int i = 0; i < N; i++) begin
         push_sample(frame_buf[i], sparse);
         acc_q.push_back(frame_buf[i]);
      end
      @(posedge i_audio_clk);
      i_audio_valid <= 1'b0;
   endtask

   task automatic queue_model_frame();
      longint          x[64];
      longint unsigned pw[64];
      for (int i = 0; i < 64; i++) x[i] = 0;
      for (int i = 0; i < N; i++) x[i] = longint'(acc_q.pop_front());
      fft_power_model(LOG2N, x, pw);
      for (int i = 0; i < N; i++) exp_q.push_back(pw[i]);
   endtask

   // spectrum known in closed form
   task automatic expect_closed_form(input power_t bin0, input power_t others);
      acc_q.delete();
      for (int i = 0; i < N; i++) exp_q.push_back((i == 0) ? bin0 : others);
   endtask

   task automatic wait_frames(input int target);
      while (frames_seen < target) @(posedge clk_50m);
   endtask

   always @(negedge clk_50m) begin
      power_t expected;
      if (i_rst) begin
         beat_cnt = 0;
      end else begin
         if (ovf_low) require(!o_overflow, "o_overflow rose although the FIFO never filled");
         if (ovf_high) require(o_overflow, "o_overflow fell before reset");
         if (o_valid) begin
            compare_value({test_name, " sop"}, beat_cnt == 0, o_beat.sop);
            compare_value({test_name, " eop"}, beat_cnt == N - 1, o_beat.eop);
            if (check_values && exp_q.size() == 0) begin
               require(1'b0, "output beat arrived with no expected power");
            end else if (check_values) begin
               expected = exp_q.pop_front();
               compare_value($sformatf("%s bin %0d", test_name, beat_cnt), expected,
                             o_beat.power);
            end
            beat_cnt = (o_beat.eop || beat_cnt == N - 1) ? 0 : beat_cnt + 1;
            if (beat_cnt == 0) frames_seen++;
         end
      end
   end

   always @(posedge clk_50m) begin
      cycles <= cycles + 1;
      if (cycles == MAX_CYCLES) begin
         $display("timeout: test did not finish within %0d cycles", cycles);
         $display("checks: %0d, errors: %0d", checks, errors);
         $display("Checks failed");
         $finish;
      end
   end

   initial begin
      audio_t a;
      int     base;
      clk_50m       = 1'b0;
      i_audio_clk   = 1'b0;
      i_rst         = 1'b1;
      i_audio_valid = 1'b0;
      i_audio_data  = '0;
      check_values  = 1'b1;
      ovf_low       = 1'b1;
      ovf_high      = 1'b0;
      test_name     = "impulse";
      apply_reset();
      foreach (frame_buf[i]) frame_buf[i] = (i == 0) ? 24'sd1000 : 24'sd0;
      send_frame(1'b0);
      expect_closed_form(64'd1000000, 64'd1000000);
      wait_frames(1);

      test_name = "constant";
      a = $random(seed) % 500000;
      foreach (frame_buf[i]) frame_buf[i] = a;
      send_frame(1'b0);
      expect_closed_form(power_t'(256 * longint'(a) * longint'(a)), '0);  // (16A)^2
      wait_frames(2);

      test_name = "random";
      for (int f = 0; f < RAND_FR; f++) begin
         foreach (frame_buf[i]) frame_buf[i] = audio_t'($random(seed));
         send_frame(1'b1);
         queue_model_frame();
         wait_frames(3 + f);
      end

      // dense burst, survivors unknown so only framing is checked
      test_name    = "burst";
      check_values = 1'b0;
      ovf_low      = 1'b0;
      for (int i = 0; i < BURST_LEN; i++) push_sample(audio_t'($random(seed)), 1'b0);
      @(posedge i_audio_clk);
      i_audio_valid <= 1'b0;
      repeat (10) @(negedge clk_50m);
      require(o_overflow, "o_overflow did not rise after the dense burst");
      ovf_high = 1'b1;
      base     = 0;
      while (base < 200) begin
         @(negedge clk_50m);
         base = o_valid ? 0 : base + 1;
      end
      require(frames_seen > 2 + RAND_FR, "no output frame came out of the burst");
      require(beat_cnt == 0, "an output frame stopped before its last beat");

      test_name = "reset";
      foreach (frame_buf[i]) frame_buf[i] = audio_t'($random(seed));
      send_frame(1'b0);
      while (!o_valid) @(negedge clk_50m);
      ovf_high = 1'b0;
      // reset lands in the middle of an unloading frame
      fork
         apply_reset();
         begin
            repeat (3) @(negedge clk_50m);
            compare_value("reset o_valid", 0, o_valid);
         end
      join
      @(negedge clk_50m);
      compare_value("reset o_overflow", 0, o_overflow);
      acc_q.delete();
      exp_q.delete();
      check_values = 1'b1;
      ovf_low      = 1'b1;
      test_name    = "after reset";
      base         = frames_seen;
      for (int f = 0; f < 4; f++) begin
         foreach (frame_buf[i]) frame_buf[i] = audio_t'($random(seed));
         send_frame(1'b1);
         queue_model_frame();
         wait_frames(base + f + 1);
      end
      require(exp_q.size() == 0, "expected powers were left without output");

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

/* verilog.f */
+incdir+tb
verilog/audio_fft_pkg.sv
verilog/audio_cdc_fifo.sv
verilog/fft_frame_ctrl.sv
verilog/fft_radix2_core.sv
verilog/spectrum_power.sv
verilog/audio_fft_top.sv
tb/audio_fft_tb.sv
